// File: common/video_pkg.sv
// raster and pixel types shared by the timing generator, pixel pipeline and checker
// a file refers to these by scoped name
package video_pkg;

   // ------------------------------
   // scalar types
   // ------------------------------

   // one pixel colour, red in bit 2, green in bit 1, blue in bit 0
   typedef logic [2:0] rgb_t;

   // pixel or line number inside the active area
   typedef logic [9:0] coord_t;

   // ------------------------------
   // per-clock video structs
   // ------------------------------

   // timing generator output, one per pixel clock
   typedef struct packed {
      logic   hsync_n;
      logic   vsync_n;
      logic   de;
      // single clock pulse at count 0,0
      logic   frame_start;
      coord_t x;
      coord_t y;
   } raster_t;

   // pipeline output, same syncs as the raster plus the colour
   typedef struct packed {
      logic   hsync_n;
      logic   vsync_n;
      logic   de;
      rgb_t   rgb;
      coord_t x;
      coord_t y;
   } pixel_t;

   // idle values, syncs inactive and everything else zero
   localparam raster_t RASTER_IDLE = '{hsync_n: 1'b1, vsync_n: 1'b1, default: '0};
   localparam pixel_t PIXEL_IDLE = '{hsync_n: 1'b1, vsync_n: 1'b1, default: '0};

endpackage

// File: common/wb_regs_pkg.sv
// Wishbone bus structs, register map and display modes of the VGA register port
// the tile write request to the tile RAM is defined here as well
package wb_regs_pkg;

   // ------------------------------
   // bus widths and structs
   // ------------------------------

   // word address and data width of the register port
   localparam int WB_AW = 14;
   localparam int WB_DW = 32;

   // master to slave, held until ack
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
   } wb_m2s_t;

   // slave to master, dat valid while ack is high
   typedef struct packed {
      logic             ack;
      logic [WB_DW-1:0] dat;
   } wb_s2m_t;

   // ------------------------------
   // register map
   // ------------------------------

   // pixel source selected by REG_CTRL bits 1:0
   typedef enum logic [1:0] {
      MODE_BLACK = 2'd0,
      MODE_SOLID = 2'd1,
      MODE_BARS  = 2'd2,
      MODE_TILES = 2'd3
   } disp_mode_e;

   localparam logic [WB_AW-1:0] REG_CTRL   = 14'd0;
   localparam logic [WB_AW-1:0] REG_SOLID  = 14'd1;
   // read only, wraps
   localparam logic [WB_AW-1:0] REG_FRAMES = 14'd2;

   // address bit that selects the tile RAM, tile index in the low bits
   localparam int TILE_SEL_BIT = 13;
   localparam int TILE_AW = 12;

   // one tile colour write from the bus side
   typedef struct packed {
      logic               we;
      logic [TILE_AW-1:0] addr;
      video_pkg::rgb_t    rgb;
   } tile_wr_t;

endpackage

// File: logic/tile_ram.sv
// simple dual-port tile colour memory, host write port and video read port
// depth is one word per tile of the active area
`timescale 1ns/1ps

module tile_ram #(
   parameter int H_ACTIVE   = 640,
   parameter int V_ACTIVE   = 480,
   parameter int TILE_SHIFT = 4
) (
   input  logic                            i_clk_25MHz,
   input  wb_regs_pkg::tile_wr_t           i_wr,
   input  logic [wb_regs_pkg::TILE_AW-1:0] i_rd_addr,
   output video_pkg::rgb_t                 o_rd_rgb
);

   // tile grid of the active area
   localparam int TILES_X = H_ACTIVE >> TILE_SHIFT;
   localparam int TILES_Y = V_ACTIVE >> TILE_SHIFT;
   localparam int DEPTH   = TILES_X * TILES_Y;
   localparam int IDX_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   video_pkg::rgb_t mem [DEPTH];

   // host port, indices past the grid are dropped
   always_ff @(posedge i_clk_25MHz) begin
      if (i_wr.we && (int'(i_wr.addr) < DEPTH)) begin
         mem[i_wr.addr[IDX_W-1:0]] <= i_wr.rgb;
      end
   end

   // video port, word valid one clock after the address
   always_ff @(posedge i_clk_25MHz) begin
      if (int'(i_rd_addr) < DEPTH) begin
         o_rd_rgb <= mem[i_rd_addr[IDX_W-1:0]];
      end else begin
         o_rd_rgb <= '0;
      end
   end

endmodule

// File: logic/wb_regs.sv
// Wishbone classic slave for the VGA control registers and frame counter
// accesses with address bit 13 set become tile RAM writes
`timescale 1ns/1ps

module wb_regs (
   input  logic                    i_clk_25MHz,
   input  logic                    i_reset,
   input  wb_regs_pkg::wb_m2s_t    i_wb,
   output wb_regs_pkg::wb_s2m_t    o_wb,
   input  video_pkg::raster_t      i_raster,
   output wb_regs_pkg::disp_mode_e o_mode,
   output video_pkg::rgb_t         o_solid,
   output wb_regs_pkg::tile_wr_t   o_tile_wr
);

   logic                                req;
   logic                                tile_sel;
   logic                                ack_q;
   logic [wb_regs_pkg::WB_DW-1:0]       rd_dat_next;
   logic [wb_regs_pkg::WB_DW-1:0]       rd_dat_q;
   logic [wb_regs_pkg::WB_DW-1:0]       frame_cnt;
   wb_regs_pkg::disp_mode_e             mode_q;
   video_pkg::rgb_t                     solid_q;
   logic                                tile_we_q;
   logic [wb_regs_pkg::TILE_AW-1:0]     tile_addr_q;
   video_pkg::rgb_t                     tile_rgb_q;

   // ------------------------------
   // decode
   // ------------------------------

   // new request, ack low blocks a second ack in a row
   assign req = i_wb.cyc && i_wb.stb && !ack_q;
   assign tile_sel = i_wb.adr[wb_regs_pkg::TILE_SEL_BIT];

   // read mux, tile RAM and unmapped addresses read zero
   always_comb begin
      rd_dat_next = '0;
      if (!tile_sel) begin
         case (i_wb.adr)
            wb_regs_pkg::REG_CTRL:   rd_dat_next[1:0] = mode_q;
            wb_regs_pkg::REG_SOLID:  rd_dat_next[2:0] = solid_q;
            wb_regs_pkg::REG_FRAMES: rd_dat_next = frame_cnt;
            default:                 rd_dat_next = '0;
         endcase
      end
   end

   // ------------------------------
   // handshake and control registers
   // ------------------------------
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         ack_q     <= 1'b0;
         tile_we_q <= 1'b0;
         mode_q    <= wb_regs_pkg::MODE_BLACK;
         solid_q   <= '0;
      end else begin
         // ack one clock after the request
         ack_q     <= req;
         // tile write request lines up with ack
         tile_we_q <= req && i_wb.we && tile_sel;
         if (req && i_wb.we && !tile_sel) begin
            case (i_wb.adr)
               wb_regs_pkg::REG_CTRL:  mode_q <= wb_regs_pkg::disp_mode_e'(i_wb.dat[1:0]);
               wb_regs_pkg::REG_SOLID: solid_q <= i_wb.dat[2:0];
               default: ;
            endcase
         end
      end
   end

   // read data and tile write payload, loaded on each request
   always_ff @(posedge i_clk_25MHz) begin
      if (req) begin
         rd_dat_q    <= rd_dat_next;
         tile_addr_q <= i_wb.adr[wb_regs_pkg::TILE_AW-1:0];
         tile_rgb_q  <= i_wb.dat[2:0];
      end
   end

   // frames seen by the timing generator, wraps
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         frame_cnt <= '0;
      end else if (i_raster.frame_start) begin
         frame_cnt <= frame_cnt + 1'b1;
      end
   end

   // ------------------------------
   // outputs
   // ------------------------------
   assign o_wb      = '{ack: ack_q, dat: rd_dat_q};
   assign o_mode    = mode_q;
   assign o_solid   = solid_q;
   assign o_tile_wr = '{we: tile_we_q, addr: tile_addr_q, rgb: tile_rgb_q};

   // classic cycle, every ack is a single clock
   a_ack_single: assert property (@(posedge i_clk_25MHz) disable iff (i_reset)
      o_wb.ack |=> !o_wb.ack);

endmodule

// File: vga/vga_timing.sv
// VGA raster timing, counts pixels and lines at the pixel clock
// emits registered syncs, data enable and active-area position
`timescale 1ns/1ps

module vga_timing #(
   parameter int H_ACTIVE = 640,
   parameter int H_FP     = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BP     = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FP     = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BP     = 33
) (
   input  logic               i_clk_25MHz,
   input  logic               i_reset,
   output video_pkg::raster_t o_raster
);

   // blanking comes first, active video last in each line and frame
   localparam int H_BLANK = H_FP + H_SYNC + H_BP;
   localparam int V_BLANK = V_FP + V_SYNC + V_BP;
   localparam int H_TOTAL = H_BLANK + H_ACTIVE;
   localparam int V_TOTAL = V_BLANK + V_ACTIVE;

   // counter compare points, in counter width
   localparam video_pkg::coord_t H_LAST       = video_pkg::coord_t'(H_TOTAL - 1);
   localparam video_pkg::coord_t V_LAST       = video_pkg::coord_t'(V_TOTAL - 1);
   localparam video_pkg::coord_t H_SYNC_START = video_pkg::coord_t'(H_FP);
   localparam video_pkg::coord_t H_SYNC_END   = video_pkg::coord_t'(H_FP + H_SYNC);
   localparam video_pkg::coord_t V_SYNC_START = video_pkg::coord_t'(V_FP);
   localparam video_pkg::coord_t V_SYNC_END   = video_pkg::coord_t'(V_FP + V_SYNC);
   localparam video_pkg::coord_t H_ACT_START  = video_pkg::coord_t'(H_BLANK);
   localparam video_pkg::coord_t V_ACT_START  = video_pkg::coord_t'(V_BLANK);

   video_pkg::coord_t h_cnt;
   video_pkg::coord_t v_cnt;
   logic              h_sync_span;
   logic              v_sync_span;
   logic              active;

   // ------------------------------
   // pixel and line counters
   // ------------------------------
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_cnt == H_LAST) begin
         // end of line, step the line counter
         h_cnt <= '0;
         v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   // sync spans follow the front porch
   assign h_sync_span = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
   assign v_sync_span = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);
   // both counters past blanking
   assign active = (h_cnt >= H_ACT_START) && (v_cnt >= V_ACT_START);

   // ------------------------------
   // registered raster output
   // ------------------------------
   // describes the counter state of the previous clock
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         o_raster <= video_pkg::RASTER_IDLE;
      end else begin
         o_raster.hsync_n     <= !h_sync_span;
         o_raster.vsync_n     <= !v_sync_span;
         o_raster.de          <= active;
         o_raster.frame_start <= (h_cnt == '0) && (v_cnt == '0);
         // position is zero outside the active area
         o_raster.x           <= active ? h_cnt - H_ACT_START : '0;
         o_raster.y           <= active ? v_cnt - V_ACT_START : '0;
      end
   end

   // line counter wraps before the line total
   a_h_in_line: assert property (@(posedge i_clk_25MHz) disable iff (i_reset)
      int'(h_cnt) < H_TOTAL);

endmodule

// File: vga/pixel_pipe.sv
// two-stage pixel pipeline that picks each pixel colour from the display mode
// keeps syncs and position aligned with the colour over 2 clocks of latency
`timescale 1ns/1ps

module pixel_pipe #(
   parameter int H_ACTIVE   = 640,
   parameter int TILE_SHIFT = 4
) (
   input  logic                                 i_clk_25MHz,
   input  logic                                 i_reset,
   input  video_pkg::raster_t                   i_raster,
   input  wb_regs_pkg::disp_mode_e              i_mode,
   input  video_pkg::rgb_t                      i_solid,
   output logic [wb_regs_pkg::TILE_AW-1:0]      o_tile_addr,
   input  video_pkg::rgb_t                      i_tile_rgb,
   output video_pkg::pixel_t                    o_pixel
);

   typedef logic [wb_regs_pkg::TILE_AW-1:0] tile_addr_t;

   // tiles in one row of the active area
   localparam int TILES_X = H_ACTIVE >> TILE_SHIFT;

   video_pkg::raster_t raster_s1;
   logic [2:0]         bar_next;
   logic [2:0]         bar_s1;
   video_pkg::rgb_t    rgb_next;

   // ------------------------------
   // stage 1
   // ------------------------------

   // the RAM registers the tile index of the incoming pixel this clock
   assign o_tile_addr = tile_addr_t'(int'(i_raster.y >> TILE_SHIFT) * TILES_X
                                     + int'(i_raster.x >> TILE_SHIFT));

   // eight equal bars across the line
   assign bar_next = 3'((int'(i_raster.x) * 8) / H_ACTIVE);

   // hold the raster while the RAM read is in flight
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         raster_s1 <= video_pkg::RASTER_IDLE;
      end else begin
         raster_s1 <= i_raster;
      end
   end

   always_ff @(posedge i_clk_25MHz) begin
      bar_s1 <= bar_next;
   end

   // ------------------------------
   // stage 2
   // ------------------------------

   // colour by mode and black outside the active area
   always_comb begin
      rgb_next = '0;
      if (raster_s1.de) begin
         case (i_mode)
            wb_regs_pkg::MODE_SOLID: rgb_next = i_solid;
            // first bar is white and the last is black
            wb_regs_pkg::MODE_BARS:  rgb_next = 3'd7 - bar_s1;
            // RAM word for this pixel arrives now
            wb_regs_pkg::MODE_TILES: rgb_next = i_tile_rgb;
            default:                 rgb_next = '0;
         endcase
      end
   end

   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         o_pixel <= video_pkg::PIXEL_IDLE;
      end else begin
         o_pixel.hsync_n <= raster_s1.hsync_n;
         o_pixel.vsync_n <= raster_s1.vsync_n;
         o_pixel.de      <= raster_s1.de;
         o_pixel.rgb     <= rgb_next;
         o_pixel.x       <= raster_s1.x;
         o_pixel.y       <= raster_s1.y;
      end
   end

   // no colour during blanking
   a_blank_black: assert property (@(posedge i_clk_25MHz) disable iff (i_reset)
      !o_pixel.de |-> (o_pixel.rgb == '0));

endmodule

// File: vga/vga_top.sv
// VGA display subsystem top, Wishbone register port in and VGA signals out
// raster geometry and tile size are set here and passed down
`timescale 1ns/1ps

module vga_top #(
   parameter int H_ACTIVE   = 640,
   parameter int H_FP       = 16,
   parameter int H_SYNC     = 96,
   parameter int H_BP       = 48,
   parameter int V_ACTIVE   = 480,
   parameter int V_FP       = 10,
   parameter int V_SYNC     = 2,
   parameter int V_BP       = 33,
   // log2 of the tile edge in pixels
   parameter int TILE_SHIFT = 4
) (
   input  logic                 i_clk_25MHz,
   input  logic                 i_reset,
   input  wb_regs_pkg::wb_m2s_t i_wb,
   output wb_regs_pkg::wb_s2m_t o_wb,
   // active low syncs
   output logic                 o_hsync,
   output logic                 o_vsync,
   output logic                 o_de,
   output logic                 o_red,
   output logic                 o_green,
   output logic                 o_blue,
   output video_pkg::coord_t    o_x,
   output video_pkg::coord_t    o_y
);

   video_pkg::raster_t                raster;
   video_pkg::pixel_t                 pixel;
   wb_regs_pkg::disp_mode_e           mode;
   video_pkg::rgb_t                   solid;
   wb_regs_pkg::tile_wr_t             tile_wr;
   logic [wb_regs_pkg::TILE_AW-1:0]   tile_rd_addr;
   video_pkg::rgb_t                   tile_rd_rgb;

   // host side
   wb_regs u_regs (
      .i_clk_25MHz (i_clk_25MHz),
      .i_reset     (i_reset),
      .i_wb        (i_wb),
      .o_wb        (o_wb),
      .i_raster    (raster),
      .o_mode      (mode),
      .o_solid     (solid),
      .o_tile_wr   (tile_wr)
   );

   tile_ram #(
      .H_ACTIVE   (H_ACTIVE),
      .V_ACTIVE   (V_ACTIVE),
      .TILE_SHIFT (TILE_SHIFT)
   ) u_tile_ram (
      .i_clk_25MHz (i_clk_25MHz),
      .i_wr        (tile_wr),
      .i_rd_addr   (tile_rd_addr),
      .o_rd_rgb    (tile_rd_rgb)
   );

   // video side
   vga_timing #(
      .H_ACTIVE (H_ACTIVE),
      .H_FP     (H_FP),
      .H_SYNC   (H_SYNC),
      .H_BP     (H_BP),
      .V_ACTIVE (V_ACTIVE),
      .V_FP     (V_FP),
      .V_SYNC   (V_SYNC),
      .V_BP     (V_BP)
   ) u_timing (
      .i_clk_25MHz (i_clk_25MHz),
      .i_reset     (i_reset),
      .o_raster    (raster)
   );

   pixel_pipe #(
      .H_ACTIVE   (H_ACTIVE),
      .TILE_SHIFT (TILE_SHIFT)
   ) u_pipe (
      .i_clk_25MHz (i_clk_25MHz),
      .i_reset     (i_reset),
      .i_raster    (raster),
      .i_mode      (mode),
      .i_solid     (solid),
      .o_tile_addr (tile_rd_addr),
      .i_tile_rgb  (tile_rd_rgb),
      .o_pixel     (pixel)
   );

   // unpack the pixel onto the output pins
   assign o_hsync = pixel.hsync_n;
   assign o_vsync = pixel.vsync_n;
   assign o_de    = pixel.de;
   assign o_red   = pixel.rgb[2];
   assign o_green = pixel.rgb[1];
   assign o_blue  = pixel.rgb[0];
   assign o_x     = pixel.x;
   assign o_y     = pixel.y;

endmodule

// File: tests/vga_checker.sv
// passive monitor that rebuilds the raster from the VGA outputs and compares each pixel
// the testbench drives the expected mode, solid colour and tile colours
`timescale 1ns/1ps

module vga_checker #(
   parameter int H_ACTIVE   = 64,
   parameter int H_TOTAL    = 80,
   parameter int H_SYNC     = 8,
   parameter int V_ACTIVE   = 48,
   parameter int V_TOTAL    = 55,
   parameter int V_SYNC     = 2,
   parameter int TILE_SHIFT = 4,
   parameter int TILES      = (H_ACTIVE >> TILE_SHIFT) * (V_ACTIVE >> TILE_SHIFT)
) (
   input  logic                    i_clk_25MHz,
   input  logic                    i_reset,
   input  logic                    i_hsync,
   input  logic                    i_vsync,
   input  logic                    i_de,
   input  video_pkg::rgb_t         i_rgb,
   input  video_pkg::coord_t       i_x,
   input  video_pkg::coord_t       i_y,
   // colour compare only while set
   input  logic                    i_check_en,
   input  wb_regs_pkg::disp_mode_e i_mode,
   input  video_pkg::rgb_t         i_solid,
   input  video_pkg::rgb_t         i_tile_model [TILES],
   output int                      o_errors,
   output int                      o_checked
);

   localparam int TILES_X = H_ACTIVE >> TILE_SHIFT;

   logic hs_q, vs_q, h_seen, v_seen;
   int   hs_clk, hs_low, vs_low, lines, de_cnt;
   // position the next active pixel should carry
   int   exp_x, exp_y;

   task automatic report_mismatch(input string name, input int exp_val, input int act_val);
      $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp_val, act_val);
      o_errors++;
   endtask

   // colour of an active pixel by display mode
   function automatic video_pkg::rgb_t model_rgb(input int x, input int y);
      case (i_mode)
         wb_regs_pkg::MODE_SOLID: return i_solid;
         wb_regs_pkg::MODE_BARS:  return video_pkg::rgb_t'(7 - (x * 8) / H_ACTIVE);
         wb_regs_pkg::MODE_TILES:
            return i_tile_model[(y >> TILE_SHIFT) * TILES_X + (x >> TILE_SHIFT)];
         default:                 return '0;
      endcase
   endfunction

   initial begin
      o_errors  = 0;
      o_checked = 0;
   end

   // outputs come from flops and the posedge sees last clock's values
   always @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         hs_q   = 1'b1;
         vs_q   = 1'b1;
         h_seen = 1'b0;
         v_seen = 1'b0;
         hs_clk = 0;
         hs_low = 0;
         vs_low = 0;
         lines  = 0;
         de_cnt = 0;
         exp_x  = 0;
         exp_y  = 0;
      end else begin
         // ------------------------------
         // line geometry
         // ------------------------------
         hs_clk++;
         if (hs_q && !i_hsync) begin
            if (h_seen && hs_clk != H_TOTAL) report_mismatch("line clocks", H_TOTAL, hs_clk);
            h_seen = 1'b1;
            hs_clk = 0;
            lines++;
         end
         if (!i_hsync) hs_low++;
         if (!hs_q && i_hsync) begin
            if (h_seen && hs_low != H_SYNC) report_mismatch("hsync low clocks", H_SYNC, hs_low);
            hs_low = 0;
         end

         // ------------------------------
         // frame geometry
         // ------------------------------
         if (vs_q && !i_vsync) begin
            if (v_seen) begin
               if (lines != V_TOTAL) report_mismatch("frame lines", V_TOTAL, lines);
               if (de_cnt != H_ACTIVE * V_ACTIVE)
                  report_mismatch("de clocks per frame", H_ACTIVE * V_ACTIVE, de_cnt);
            end
            v_seen = 1'b1;
            lines  = 0;
            de_cnt = 0;
            exp_x  = 0;
            exp_y  = 0;
         end
         if (!i_vsync) vs_low++;
         if (!vs_q && i_vsync) begin
            if (v_seen && vs_low != V_SYNC * H_TOTAL)
               report_mismatch("vsync low clocks", V_SYNC * H_TOTAL, vs_low);
            vs_low = 0;
         end

         // ------------------------------
         // position and colour
         // ------------------------------
         if (i_de) begin
            de_cnt++;
            if (int'(i_x) != exp_x) report_mismatch("o_x", exp_x, int'(i_x));
            if (int'(i_y) != exp_y) report_mismatch("o_y", exp_y, int'(i_y));
            if (i_check_en) begin
               if (i_rgb != model_rgb(exp_x, exp_y))
                  report_mismatch("rgb", int'(model_rgb(exp_x, exp_y)), int'(i_rgb));
               o_checked++;
            end
            exp_x++;
            if (exp_x == H_ACTIVE) begin
               exp_x = 0;
               exp_y++;
            end
         end else begin
            // blanking is black at position 0,0
            if (i_rgb != '0) report_mismatch("rgb in blanking", 0, int'(i_rgb));
            if (i_x != '0) report_mismatch("o_x in blanking", 0, int'(i_x));
            if (i_y != '0) report_mismatch("o_y in blanking", 0, int'(i_y));
         end
         hs_q = i_hsync;
         vs_q = i_vsync;
      end
   end

endmodule

// File: tests/tb_vga.sv
// testbench for the VGA subsystem on a tiny 64x48 raster
// applies a table of display settings over Wishbone while the checker compares the pixels
`timescale 1ns/1ps

module tb_vga;

   localparam int H_ACTIVE = 64, H_FP = 4, H_SYNC = 8, H_BP = 4;
   localparam int V_ACTIVE = 48, V_FP = 2, V_SYNC = 2, V_BP = 3;
   localparam int TILE_SHIFT = 4;
   localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
   localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
   localparam int TILES = (H_ACTIVE >> TILE_SHIFT) * (V_ACTIVE >> TILE_SHIFT);
   localparam int CLK_PERIOD = 40;
   localparam int FRAME_NS = H_TOTAL * V_TOTAL * CLK_PERIOD;

   // one table row with new tiles drawn when fill is set
   typedef struct packed {
      wb_regs_pkg::disp_mode_e mode;
      video_pkg::rgb_t         solid;
      logic                    fill;
      logic [7:0]              frames;
   } stim_t;

   localparam int NUM_ROWS = 6;
   localparam stim_t STIM [NUM_ROWS] = '{
      '{wb_regs_pkg::MODE_SOLID, 3'd5, 1'b0, 8'd1},
      '{wb_regs_pkg::MODE_SOLID, 3'd2, 1'b0, 8'd1},
      '{wb_regs_pkg::MODE_BARS,  3'd3, 1'b0, 8'd2},
      '{wb_regs_pkg::MODE_BLACK, 3'd4, 1'b0, 8'd1},
      '{wb_regs_pkg::MODE_TILES, 3'd0, 1'b1, 8'd2},
      '{wb_regs_pkg::MODE_TILES, 3'd6, 1'b1, 8'd1}
   };

   logic                    clk, reset;
   wb_regs_pkg::wb_m2s_t    wb_m;
   wb_regs_pkg::wb_s2m_t    wb_s;
   logic                    hsync, vsync, de, red, green, blue;
   video_pkg::coord_t       x, y;
   logic                    check_en;
   wb_regs_pkg::disp_mode_e cur_mode;
   video_pkg::rgb_t         cur_solid;
   video_pkg::rgb_t         tile_model [TILES];
   int                      bus_errors, chk_errors, pixels_checked;
   integer                  seed;

   vga_top #(
      .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
      .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP),
      .TILE_SHIFT (TILE_SHIFT)
   ) u_dut (
      .i_clk_25MHz (clk), .i_reset (reset), .i_wb (wb_m), .o_wb (wb_s),
      .o_hsync (hsync), .o_vsync (vsync), .o_de (de),
      .o_red (red), .o_green (green), .o_blue (blue), .o_x (x), .o_y (y)
   );

   vga_checker #(
      .H_ACTIVE (H_ACTIVE), .H_TOTAL (H_TOTAL), .H_SYNC (H_SYNC),
      .V_ACTIVE (V_ACTIVE), .V_TOTAL (V_TOTAL), .V_SYNC (V_SYNC),
      .TILE_SHIFT (TILE_SHIFT), .TILES (TILES)
   ) u_chk (
      .i_clk_25MHz (clk), .i_reset (reset), .i_hsync (hsync), .i_vsync (vsync),
      .i_de (de), .i_rgb ({red, green, blue}), .i_x (x), .i_y (y),
      .i_check_en (check_en), .i_mode (cur_mode), .i_solid (cur_solid),
      .i_tile_model (tile_model), .o_errors (chk_errors), .o_checked (pixels_checked)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------
   // bus tasks
   // ------------------------------

   // one classic cycle from a falling edge with ack expected after exactly one clock
   task automatic bus_cycle(input logic we, input logic [13:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
      int cycles;
      cycles = 0;
      wb_m = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
      do begin
         @(negedge clk);
         cycles++;
      end while (!wb_s.ack && cycles < 16);
      rdat = wb_s.dat;
      if (cycles != 1 || !wb_s.ack) begin
         $display("bus access to address %0h was not acked after one clock", adr);
         bus_errors++;
      end
      wb_m = '0;
      @(negedge clk);
      if (wb_s.ack) begin
         $display("ack for address %0h stayed high for a second clock", adr);
         bus_errors++;
      end
   endtask

   task automatic bus_write(input logic [13:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, dat, unused);
   endtask

   task automatic bus_read(input logic [13:0] adr, output logic [31:0] dat);
      bus_cycle(1'b0, adr, '0, dat);
   endtask

   task automatic check_reg(input string name, input logic [13:0] adr, input logic [31:0] exp_val);
      logic [31:0] rdat;
      bus_read(adr, rdat);
      if (rdat !== exp_val) begin
         $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp_val, rdat);
         bus_errors++;
      end
   endtask

   // random colour per tile written into the RAM and the checker model
   task automatic fill_tiles();
      logic [13:0]     adr;
      video_pkg::rgb_t c;
      for (int i = 0; i < TILES; i++) begin
         c = video_pkg::rgb_t'($random(seed));
         tile_model[i] = c;
         adr = '0;
         adr[wb_regs_pkg::TILE_SEL_BIT] = 1'b1;
         adr[wb_regs_pkg::TILE_AW-1:0] = i[wb_regs_pkg::TILE_AW-1:0];
         bus_write(adr, 32'(c));
      end
   endtask

   // returns on the falling clock edge after the n-th vsync fall
   task automatic wait_frames(input int n);
      repeat (n) @(negedge vsync);
      @(negedge clk);
   endtask

   // ------------------------------
   // stimulus
   // ------------------------------
   initial begin
      logic [31:0] frames_a, frames_b;
      reset      = 1'b1;
      wb_m       = '0;
      check_en   = 1'b0;
      cur_mode   = wb_regs_pkg::MODE_BLACK;
      cur_solid  = '0;
      bus_errors = 0;
      seed       = 32'ha100;
      for (int i = 0; i < TILES; i++) tile_model[i] = '0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      for (int row = 0; row < NUM_ROWS; row++) begin
         check_en = 1'b0;
         if (STIM[row].fill) fill_tiles();
         bus_write(wb_regs_pkg::REG_CTRL, 32'(STIM[row].mode));
         bus_write(wb_regs_pkg::REG_SOLID, 32'(STIM[row].solid));
         check_reg("REG_CTRL", wb_regs_pkg::REG_CTRL, 32'(STIM[row].mode));
         check_reg("REG_SOLID", wb_regs_pkg::REG_SOLID, 32'(STIM[row].solid));
         cur_mode  = STIM[row].mode;
         cur_solid = STIM[row].solid;
         // new settings are in place well before the next active area
         wait_frames(1);
         bus_read(wb_regs_pkg::REG_FRAMES, frames_a);
         check_en = 1'b1;
         wait_frames(int'(STIM[row].frames));
         check_en = 1'b0;
         bus_read(wb_regs_pkg::REG_FRAMES, frames_b);
         if (frames_b - frames_a != 32'(STIM[row].frames)) begin
            $display("** Error at %0t ns: REG_FRAMES step expected %0d, got %0d",
                     $time, STIM[row].frames, frames_b - frames_a);
            bus_errors++;
         end
      end

      if (pixels_checked == 0) $display("no active pixel was compared during the run");
      $display("checker errors %0d, bus errors %0d, pixels checked %0d",
               chk_errors, bus_errors, pixels_checked);
      if (chk_errors == 0 && bus_errors == 0 && pixels_checked > 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // settle frame plus check frames per row and some spare frames
   initial begin
      int total_frames;
      total_frames = 0;
      for (int i = 0; i < NUM_ROWS; i++) total_frames += 1 + int'(STIM[i].frames);
      #((total_frames + 4) * FRAME_NS);
      $display("timeout, the run did not finish within %0d frames", total_frames + 4);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: flist.f
common/video_pkg.sv
common/wb_regs_pkg.sv
logic/tile_ram.sv
logic/wb_regs.sv
vga/vga_timing.sv
vga/pixel_pipe.sv
vga/vga_top.sv
tests/vga_checker.sv
tests/tb_vga.sv

// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = tb_vga
FLIST   = flist.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
